//--- src/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

`define RISCV_XLEN       64   // integer datapath width
`define RISCV_REG_COUNT  32   // x0..x31
`define RISCV_CNT_WIDTH  64   // minstret style counters

`endif

//--- src/riscv_isa_pkg.sv
`include "riscv_config.svh"

package riscv_isa_pkg;

    typedef logic [4:0]             reg_idx_t;
    typedef logic [`RISCV_XLEN-1:0] xlen_t;

    typedef enum logic [2:0] {
        RES_ALU     = 3'd0,
        RES_LOAD    = 3'd1,
        RES_UIMM    = 3'd2,   // lui / auipc immediate
        RES_PCPLUS4 = 3'd3,   // jal / jalr link
        RES_SC      = 3'd4    // sc.w / sc.d status
    } result_src_e;

    // load funct3
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } load_size_e;

    typedef enum logic [1:0] {
        RET_NONE = 2'd0,
        RET_SRET = 2'd1,
        RET_MRET = 2'd2
    } trap_ret_e;

    typedef union packed {
        logic [`RISCV_XLEN/8-1:0][7:0]   bytes;
        logic [`RISCV_XLEN/16-1:0][15:0] halves;
        logic [`RISCV_XLEN/32-1:0][31:0] words;
        logic [`RISCV_XLEN-1:0]          dword;
    } load_word_u;

endpackage

//--- src/riscv_pipe_pkg.sv
package riscv_pipe_pkg;

    // payload leaving the memory stage
    typedef struct packed {
        riscv_isa_pkg::xlen_t       pcplus4;
        riscv_isa_pkg::xlen_t       result;      // alu / address result
        riscv_isa_pkg::xlen_t       uimm;
        riscv_isa_pkg::xlen_t       memload;     // filled by the load aligner
        riscv_isa_pkg::xlen_t       csrout;
        riscv_isa_pkg::xlen_t       rddata_sc;
        riscv_isa_pkg::reg_idx_t    rdaddr;
        riscv_isa_pkg::result_src_e resultsrc;
        logic                       regw;
        logic                       iscsr;
        logic                       gototrap;
        logic                       instret;
        riscv_isa_pkg::trap_ret_e   returnfromtrap;
    } mem_stage_t;

    // payload held in writeback
    typedef struct packed {
        riscv_isa_pkg::xlen_t       pcplus4;
        riscv_isa_pkg::xlen_t       result;
        riscv_isa_pkg::xlen_t       uimm;
        riscv_isa_pkg::xlen_t       memload;
        riscv_isa_pkg::xlen_t       csrout;
        riscv_isa_pkg::xlen_t       rddata_sc;
        riscv_isa_pkg::reg_idx_t    rdaddr;
        riscv_isa_pkg::result_src_e resultsrc;
        logic                       regw;
        logic                       iscsr;
        logic                       gototrap;
        logic                       instret;     // single cycle retire pulse
        riscv_isa_pkg::trap_ret_e   returnfromtrap;
    } wb_stage_t;

endpackage

//--- src/riscv_load_align.sv
`timescale 1ns/1ps

module riscv_load_align (
    input  riscv_isa_pkg::xlen_t      i_riscv_mw_memrdata,
    input  logic [2:0]                i_riscv_mw_memaddr_lo,
    input  riscv_isa_pkg::load_size_e i_riscv_mw_loadsize,
    output riscv_isa_pkg::xlen_t      o_riscv_mw_memload
);

    import riscv_isa_pkg::*;

    load_word_u  word;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;
    logic        misaligned;

    assign word   = i_riscv_mw_memrdata;                       // raw doubleword
    assign lane_b = word.bytes[i_riscv_mw_memaddr_lo];
    assign lane_h = word.halves[i_riscv_mw_memaddr_lo[2:1]];
    assign lane_w = word.words[i_riscv_mw_memaddr_lo[2]];

    always_comb begin : load_ext_proc
        case (i_riscv_mw_loadsize)
            LB:      o_riscv_mw_memload = xlen_t'(signed'(lane_b));
            LH:      o_riscv_mw_memload = xlen_t'(signed'(lane_h));
            LW:      o_riscv_mw_memload = xlen_t'(signed'(lane_w));
            LD:      o_riscv_mw_memload = word.dword;
            LBU:     o_riscv_mw_memload = xlen_t'(lane_b);
            LHU:     o_riscv_mw_memload = xlen_t'(lane_h);
            LWU:     o_riscv_mw_memload = xlen_t'(lane_w);
            default: o_riscv_mw_memload = '0;             // funct3 7 unused
        endcase
    end

    assign misaligned =
        (((i_riscv_mw_loadsize == LH) || (i_riscv_mw_loadsize == LHU)) &&
         i_riscv_mw_memaddr_lo[0]) ||
        (((i_riscv_mw_loadsize == LW) || (i_riscv_mw_loadsize == LWU)) &&
         (|i_riscv_mw_memaddr_lo[1:0])) ||
        ((i_riscv_mw_loadsize == LD) && (|i_riscv_mw_memaddr_lo));

    // misaligned accesses trap upstream and never reach this stage
    always_comb begin : align_chk_proc
        a_load_aligned : assert final (
            $isunknown({i_riscv_mw_loadsize, i_riscv_mw_memaddr_lo}) || !misaligned
        ) else $error("misaligned load size %0d offset %0d",
                      i_riscv_mw_loadsize, i_riscv_mw_memaddr_lo);
    end

endmodule

//--- src/riscv_ppreg_mw.sv
`timescale 1ns/1ps

module riscv_ppreg_mw (
    input  logic                       i_riscv_mw_clk,
    input  logic                       i_riscv_mw_rst,
    input  logic                       i_riscv_mw_en,      // stall, high holds
    input  logic                       i_riscv_mw_flush,   // trap flush
    input  riscv_pipe_pkg::mem_stage_t i_riscv_mw_mem,
    output riscv_pipe_pkg::wb_stage_t  o_riscv_mw_wb
);

    import riscv_pipe_pkg::*;

    wb_stage_t wb_load;

    // memory stage fields mapped into writeback
    always_comb begin : mw_map_proc
        wb_load.pcplus4        = i_riscv_mw_mem.pcplus4;
        wb_load.result         = i_riscv_mw_mem.result;
        wb_load.uimm           = i_riscv_mw_mem.uimm;
        wb_load.memload        = i_riscv_mw_mem.memload;
        wb_load.csrout         = i_riscv_mw_mem.csrout;
        wb_load.rddata_sc      = i_riscv_mw_mem.rddata_sc;
        wb_load.rdaddr         = i_riscv_mw_mem.rdaddr;
        wb_load.resultsrc      = i_riscv_mw_mem.resultsrc;
        wb_load.regw           = i_riscv_mw_mem.regw;
        wb_load.iscsr          = i_riscv_mw_mem.iscsr;
        wb_load.gototrap       = i_riscv_mw_mem.gototrap;
        wb_load.instret        = i_riscv_mw_mem.instret;
        wb_load.returnfromtrap = i_riscv_mw_mem.returnfromtrap;
    end

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin : mw_pff_write_proc
        if (i_riscv_mw_rst) begin
            o_riscv_mw_wb <= '0;
        end else if (i_riscv_mw_flush) begin
            o_riscv_mw_wb <= '0;                     // bubble
        end else if (!i_riscv_mw_en) begin
            o_riscv_mw_wb <= wb_load;
        end else begin
            o_riscv_mw_wb.instret <= 1'b0;           // retire only once
        end
    end

    a_ctrl_known : assert property (
        @(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
        !$isunknown({i_riscv_mw_en, i_riscv_mw_flush, i_riscv_mw_mem.regw,
                     i_riscv_mw_mem.instret, i_riscv_mw_mem.gototrap})
    ) else $error("unknown stall, flush or control bit at the mw register");

endmodule

//--- src/riscv_wb_mux.sv
`timescale 1ns/1ps

module riscv_wb_mux (
    input  riscv_pipe_pkg::wb_stage_t i_riscv_mw_wb,
    output riscv_isa_pkg::xlen_t      o_riscv_mw_rddata
);

    import riscv_isa_pkg::*;

    always_comb begin : wb_sel_proc
        if (i_riscv_mw_wb.iscsr) begin
            o_riscv_mw_rddata = i_riscv_mw_wb.csrout;      // old csr value to rd
        end else begin
            case (i_riscv_mw_wb.resultsrc)
                RES_ALU:     o_riscv_mw_rddata = i_riscv_mw_wb.result;
                RES_LOAD:    o_riscv_mw_rddata = i_riscv_mw_wb.memload;
                RES_UIMM:    o_riscv_mw_rddata = i_riscv_mw_wb.uimm;
                RES_PCPLUS4: o_riscv_mw_rddata = i_riscv_mw_wb.pcplus4;
                RES_SC:      o_riscv_mw_rddata = i_riscv_mw_wb.rddata_sc;
                default:     o_riscv_mw_rddata = '0;
            endcase
        end
    end

endmodule

//--- src/riscv_regfile.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_regfile (
    input  logic                    i_riscv_mw_clk,
    input  logic                    i_riscv_mw_rst,
    input  logic                    i_riscv_mw_we,
    input  riscv_isa_pkg::reg_idx_t i_riscv_mw_wraddr,
    input  riscv_isa_pkg::xlen_t    i_riscv_mw_wrdata,
    input  riscv_isa_pkg::reg_idx_t i_riscv_mw_rs1addr,
    input  riscv_isa_pkg::reg_idx_t i_riscv_mw_rs2addr,
    output riscv_isa_pkg::xlen_t    o_riscv_mw_rs1data,
    output riscv_isa_pkg::xlen_t    o_riscv_mw_rs2data
);

    import riscv_isa_pkg::*;

    xlen_t regs [`RISCV_REG_COUNT];
    logic  wr_en;

    assign wr_en = i_riscv_mw_we && (i_riscv_mw_wraddr != '0);   // x0 never written

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin : rf_write_proc
        if (i_riscv_mw_rst) begin
            for (int i = 0; i < `RISCV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_riscv_mw_wraddr] <= i_riscv_mw_wrdata;
        end
    end

    function automatic xlen_t rd_port(input reg_idx_t addr, input logic we,
                                      input reg_idx_t wa, input xlen_t wd,
                                      input xlen_t stored);
        if (addr == '0) begin
            return '0;
        end else if (we && (addr == wa)) begin
            return wd;                                 // write-through
        end
        return stored;
    endfunction

    always_comb begin : rf_read_proc
        o_riscv_mw_rs1data = rd_port(i_riscv_mw_rs1addr, wr_en, i_riscv_mw_wraddr,
                                     i_riscv_mw_wrdata, regs[i_riscv_mw_rs1addr]);
        o_riscv_mw_rs2data = rd_port(i_riscv_mw_rs2addr, wr_en, i_riscv_mw_wraddr,
                                     i_riscv_mw_wrdata, regs[i_riscv_mw_rs2addr]);
    end

endmodule

//--- src/riscv_retire_counter.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_retire_counter (
    input  logic                        i_riscv_mw_clk,
    input  logic                        i_riscv_mw_rst,
    input  logic                        i_riscv_mw_instret,
    input  logic                        i_riscv_mw_gototrap,
    input  riscv_isa_pkg::trap_ret_e    i_riscv_mw_returnfromtrap,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_minstret,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_trapcount,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_retcount
);

    import riscv_isa_pkg::*;

    logic      gototrap_q;
    trap_ret_e ret_q;
    logic      trap_rise;
    logic      ret_rise;

    // a stalled trap or return stays high, count the edge only
    assign trap_rise = i_riscv_mw_gototrap && !gototrap_q;
    assign ret_rise  = (i_riscv_mw_returnfromtrap != RET_NONE) && (ret_q == RET_NONE);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin : cnt_proc
        if (i_riscv_mw_rst) begin
            gototrap_q           <= 1'b0;
            ret_q                <= RET_NONE;
            o_riscv_mw_minstret  <= '0;
            o_riscv_mw_trapcount <= '0;
            o_riscv_mw_retcount  <= '0;
        end else begin
            gototrap_q <= i_riscv_mw_gototrap;
            ret_q      <= i_riscv_mw_returnfromtrap;
            if (i_riscv_mw_instret) begin
                o_riscv_mw_minstret <= o_riscv_mw_minstret + 1'b1;
            end
            if (trap_rise) begin
                o_riscv_mw_trapcount <= o_riscv_mw_trapcount + 1'b1;
            end
            if (ret_rise) begin
                o_riscv_mw_retcount <= o_riscv_mw_retcount + 1'b1;
            end
        end
    end

    a_ret_kind_legal : assert property (
        @(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
        i_riscv_mw_returnfromtrap != 2'd3
    ) else $error("undefined trap return kind");

endmodule

//--- src/riscv_mw_top.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_mw_top (
    input  logic                        i_riscv_mw_clk,
    input  logic                        i_riscv_mw_rst,
    input  riscv_pipe_pkg::mem_stage_t  i_riscv_mw_mem,        // memload field unused
    input  riscv_isa_pkg::xlen_t        i_riscv_mw_memrdata,
    input  logic [2:0]                  i_riscv_mw_memaddr_lo,
    input  riscv_isa_pkg::load_size_e   i_riscv_mw_loadsize,
    input  logic                        i_riscv_mw_en,         // stall from hazard unit
    input  logic                        i_riscv_mw_flush,
    input  riscv_isa_pkg::reg_idx_t     i_riscv_mw_rs1addr,
    input  riscv_isa_pkg::reg_idx_t     i_riscv_mw_rs2addr,
    output riscv_pipe_pkg::wb_stage_t   o_riscv_mw_wb,
    output riscv_isa_pkg::xlen_t        o_riscv_mw_rddata,
    output riscv_isa_pkg::xlen_t        o_riscv_mw_rs1data,
    output riscv_isa_pkg::xlen_t        o_riscv_mw_rs2data,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_minstret,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_trapcount,
    output logic [`RISCV_CNT_WIDTH-1:0] o_riscv_mw_retcount
);

    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    xlen_t      memload;
    mem_stage_t mem_merged;
    logic       rf_we;

    always_comb begin : mem_merge_proc
        mem_merged         = i_riscv_mw_mem;
        mem_merged.memload = memload;              // aligned load replaces raw field
    end

    assign rf_we = o_riscv_mw_wb.regw && !o_riscv_mw_wb.gototrap;   // trapped instr no write

    riscv_load_align u_load_align (
        .i_riscv_mw_memrdata   (i_riscv_mw_memrdata),
        .i_riscv_mw_memaddr_lo (i_riscv_mw_memaddr_lo),
        .i_riscv_mw_loadsize   (i_riscv_mw_loadsize),
        .o_riscv_mw_memload    (memload)
    );

    riscv_ppreg_mw u_ppreg_mw (
        .i_riscv_mw_clk   (i_riscv_mw_clk),
        .i_riscv_mw_rst   (i_riscv_mw_rst),
        .i_riscv_mw_en    (i_riscv_mw_en),
        .i_riscv_mw_flush (i_riscv_mw_flush),
        .i_riscv_mw_mem   (mem_merged),
        .o_riscv_mw_wb    (o_riscv_mw_wb)
    );

    riscv_wb_mux u_wb_mux (
        .i_riscv_mw_wb     (o_riscv_mw_wb),
        .o_riscv_mw_rddata (o_riscv_mw_rddata)
    );

    riscv_regfile u_regfile (
        .i_riscv_mw_clk     (i_riscv_mw_clk),
        .i_riscv_mw_rst     (i_riscv_mw_rst),
        .i_riscv_mw_we      (rf_we),
        .i_riscv_mw_wraddr  (o_riscv_mw_wb.rdaddr),
        .i_riscv_mw_wrdata  (o_riscv_mw_rddata),
        .i_riscv_mw_rs1addr (i_riscv_mw_rs1addr),
        .i_riscv_mw_rs2addr (i_riscv_mw_rs2addr),
        .o_riscv_mw_rs1data (o_riscv_mw_rs1data),
        .o_riscv_mw_rs2data (o_riscv_mw_rs2data)
    );

    riscv_retire_counter u_retire_counter (
        .i_riscv_mw_clk            (i_riscv_mw_clk),
        .i_riscv_mw_rst            (i_riscv_mw_rst),
        .i_riscv_mw_instret        (o_riscv_mw_wb.instret),
        .i_riscv_mw_gototrap       (o_riscv_mw_wb.gototrap),
        .i_riscv_mw_returnfromtrap (o_riscv_mw_wb.returnfromtrap),
        .o_riscv_mw_minstret       (o_riscv_mw_minstret),
        .o_riscv_mw_trapcount      (o_riscv_mw_trapcount),
        .o_riscv_mw_retcount       (o_riscv_mw_retcount)
    );

endmodule

//--- sim/tb_riscv_mw_top.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module tb_riscv_mw_top;

    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    localparam int CNT_W = `RISCV_CNT_WIDTH;

    logic             clk;
    logic             rst;
    mem_stage_t       mem;
    xlen_t            memrdata;
    logic [2:0]       memaddr_lo;
    load_size_e       loadsize;
    logic             en;
    logic             flush;
    reg_idx_t         rs1addr;
    reg_idx_t         rs2addr;
    wb_stage_t        wb;
    xlen_t            rddata;
    xlen_t            rs1data;
    xlen_t            rs2data;
    logic [CNT_W-1:0] minstret;
    logic [CNT_W-1:0] trapcount;
    logic [CNT_W-1:0] retcount;

    logic [31:0]      lcg_state = 32'h17c8c2af;
    xlen_t            shadow_regs [`RISCV_REG_COUNT];   // expected register contents
    logic [CNT_W-1:0] exp_instret;
    logic [CNT_W-1:0] exp_traps;
    logic [CNT_W-1:0] exp_rets;
    string            test_name;
    int               value_errors;
    int               timeout_errors;

    riscv_mw_top u_riscv_mw_top (
        .i_riscv_mw_clk        (clk),
        .i_riscv_mw_rst        (rst),
        .i_riscv_mw_mem        (mem),
        .i_riscv_mw_memrdata   (memrdata),
        .i_riscv_mw_memaddr_lo (memaddr_lo),
        .i_riscv_mw_loadsize   (loadsize),
        .i_riscv_mw_en         (en),
        .i_riscv_mw_flush      (flush),
        .i_riscv_mw_rs1addr    (rs1addr),
        .i_riscv_mw_rs2addr    (rs2addr),
        .o_riscv_mw_wb         (wb),
        .o_riscv_mw_rddata     (rddata),
        .o_riscv_mw_rs1data    (rs1data),
        .o_riscv_mw_rs2data    (rs2data),
        .o_riscv_mw_minstret   (minstret),
        .o_riscv_mw_trapcount  (trapcount),
        .o_riscv_mw_retcount   (retcount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t rand_xlen();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // random data fields, control bits quiet
    function automatic mem_stage_t rand_payload();
        mem_stage_t m;
        m           = '0;
        m.pcplus4   = rand_xlen();
        m.result    = rand_xlen();
        m.uimm      = rand_xlen();
        m.memload   = rand_xlen();                // dut replaces this field
        m.csrout    = rand_xlen();
        m.rddata_sc = rand_xlen();
        m.rdaddr    = reg_idx_t'(lcg_next());
        return m;
    endfunction

    // sz follows funct3, off is the byte offset in the doubleword
    function automatic xlen_t expected_load(input xlen_t raw, input int sz, input int off);
        xlen_t lane;
        lane = raw >> (8 * off);
        case (sz)
            0: return {{(`RISCV_XLEN-8){lane[7]}}, lane[7:0]};
            1: return {{(`RISCV_XLEN-16){lane[15]}}, lane[15:0]};
            2: return {{(`RISCV_XLEN-32){lane[31]}}, lane[31:0]};
            4: return {{(`RISCV_XLEN-8){1'b0}}, lane[7:0]};
            5: return {{(`RISCV_XLEN-16){1'b0}}, lane[15:0]};
            6: return {{(`RISCV_XLEN-32){1'b0}}, lane[31:0]};
            default: return raw;
        endcase
    endfunction

    function automatic xlen_t expected_rd(input mem_stage_t m, input xlen_t ld);
        logic [2:0] code;
        code = m.resultsrc;
        if (m.iscsr) begin
            return m.csrout;
        end
        case (code)
            3'd0: return m.result;
            3'd1: return ld;
            3'd2: return m.uimm;
            3'd3: return m.pcplus4;
            3'd4: return m.rddata_sc;
            default: return '0;
        endcase
    endfunction

    function automatic wb_stage_t to_wb(input mem_stage_t m, input xlen_t ld);
        wb_stage_t w;
        w         = wb_stage_t'(m);
        w.memload = ld;
        return w;
    endfunction

    task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_wb(input string what, input wb_stage_t exp, input wb_stage_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic drive_idle();
        mem        = '0;
        memrdata   = '0;
        memaddr_lo = 3'd0;
        loadsize   = LD;
        en         = 1'b0;
        flush      = 1'b0;
    endtask

    task automatic wait_for_minstret(input logic [CNT_W-1:0] target);
        int cycles;
        cycles = 0;
        while ((minstret !== target) && (cycles < 8)) begin
            @(negedge clk);
            cycles++;
        end
        if (minstret !== target) begin
            timeout_errors++;
            $display("%s: timed out waiting for minstret to reach %0d", test_name, target);
        end
    endtask

    // pipeline drained, then counters compared
    task automatic settle();
        drive_idle();
        @(negedge clk);
        wait_for_minstret(exp_instret);
        check_count("minstret", exp_instret, minstret);
        check_count("trapcount", exp_traps, trapcount);
        check_count("retcount", exp_rets, retcount);
    endtask

    task automatic check_reg(input int idx);
        rs1addr = reg_idx_t'(idx);
        rs2addr = reg_idx_t'(idx);
        @(negedge clk);
        check_xlen($sformatf("rs1 x%0d", idx), shadow_regs[idx], rs1data);
        check_xlen($sformatf("rs2 x%0d", idx), shadow_regs[idx], rs2data);
    endtask

    task automatic issue_slot(input mem_stage_t m, input int stalls);
        mem = m;
        en  = 1'b0;
        @(negedge clk);
        en = 1'b1;
        repeat (stalls) @(negedge clk);
        drive_idle();
        @(negedge clk);
    endtask

    task automatic test_reset_passthrough();
        mem_stage_t m;
        xlen_t      raw;
        test_name = "reset_passthrough";
        check_wb("wb after reset", '0, wb);
        check_count("minstret after reset", '0, minstret);
        check_count("trapcount after reset", '0, trapcount);
        check_count("retcount after reset", '0, retcount);
        m         = rand_payload();
        m.instret = 1'b1;
        m.iscsr   = 1'b1;
        raw       = rand_xlen();
        mem       = m;
        memrdata  = raw;                          // LD at offset 0 passes the word through
        @(negedge clk);
        check_wb("wb one edge later", to_wb(m, raw), wb);
        exp_instret++;
        drive_idle();
        @(negedge clk);
        check_wb("wb back to idle", '0, wb);
        settle();
    endtask

    task automatic test_load_align();
        mem_stage_t m;
        xlen_t      raw;
        xlen_t      exp_load;
        int         sz;
        int         nbytes;
        int         off;
        test_name = "load_align";
        for (sz = 0; sz < 7; sz++) begin
            nbytes = 1 << (sz % 4);
            for (off = 0; off < 8; off += nbytes) begin
                m           = rand_payload();
                m.resultsrc = RES_LOAD;
                m.instret   = 1'b1;
                raw         = rand_xlen();
                exp_load    = expected_load(raw, sz, off);
                mem         = m;
                memrdata    = raw;
                memaddr_lo  = 3'(off);
                loadsize    = load_size_e'(sz);
                @(negedge clk);
                check_xlen($sformatf("size %0d offset %0d rddata", sz, off), exp_load, rddata);
                check_wb($sformatf("size %0d offset %0d wb", sz, off), to_wb(m, exp_load), wb);
                exp_instret++;
            end
        end
        settle();
    endtask

    task automatic test_result_select();
        mem_stage_t m;
        xlen_t      exp_data;
        logic       will_write;
        int         k;
        test_name = "result_select";
        for (k = 0; k < 11; k++) begin
            m         = rand_payload();
            m.regw    = 1'b1;
            m.instret = 1'b1;
            m.rdaddr  = reg_idx_t'(k + 1);
            if (k < 8) begin
                m.resultsrc = result_src_e'(3'(k));
            end else if (k == 8) begin
                m.iscsr     = 1'b1;
                m.resultsrc = RES_LOAD;           // csr path wins
            end else if (k == 9) begin
                m.rdaddr = '0;
            end else begin
                m.gototrap = 1'b1;
                m.instret  = 1'b0;
            end
            exp_data   = expected_rd(m, '0);
            will_write = m.regw && !m.gototrap && (m.rdaddr != '0);
            mem        = m;
            rs1addr    = m.rdaddr;
            rs2addr    = m.rdaddr;
            @(negedge clk);
            check_xlen($sformatf("case %0d rddata", k), exp_data, rddata);
            check_xlen($sformatf("case %0d same cycle rs1", k),
                       will_write ? exp_data : shadow_regs[m.rdaddr], rs1data);
            check_xlen($sformatf("case %0d same cycle rs2", k),
                       will_write ? exp_data : shadow_regs[m.rdaddr], rs2data);
            if (will_write) begin
                shadow_regs[m.rdaddr] = exp_data;
            end
            exp_instret += m.instret;
            exp_traps   += m.gototrap;
            drive_idle();
            @(negedge clk);
            check_xlen($sformatf("case %0d rs1 readback", k), shadow_regs[m.rdaddr], rs1data);
            check_xlen($sformatf("case %0d rs2 readback", k), shadow_regs[m.rdaddr], rs2data);
        end
        settle();
    endtask

    task automatic test_flush();
        mem_stage_t m;
        test_name = "flush";
        m         = rand_payload();
        m.regw    = 1'b1;
        m.instret = 1'b1;
        m.rdaddr  = 5'd12;
        mem       = m;
        flush     = 1'b1;
        @(negedge clk);
        check_wb("wb after flush", '0, wb);
        check_xlen("rddata after flush", '0, rddata);
        settle();
        check_reg(12);
    endtask

    task automatic test_stall();
        mem_stage_t       m;
        wb_stage_t        exp_w;
        logic [CNT_W-1:0] start;
        int               i;
        test_name = "stall";
        m         = rand_payload();
        m.regw    = 1'b1;
        m.instret = 1'b1;
        m.rdaddr  = 5'd13;
        exp_w     = to_wb(m, '0);
        start     = exp_instret;
        mem       = m;
        @(negedge clk);
        check_wb("wb loaded", exp_w, wb);
        en            = 1'b1;
        mem           = rand_payload();           // held off by the stall
        exp_w.instret = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_wb($sformatf("wb frozen cycle %0d", i), exp_w, wb);
            check_count($sformatf("minstret stall cycle %0d", i), start + 1, minstret);
        end
        exp_instret++;
        shadow_regs[13] = m.result;
        settle();
        check_reg(13);
    endtask

    task automatic test_trap_counters();
        mem_stage_t m;
        int         n;
        test_name = "trap_counters";
        for (n = 0; n < 6; n++) begin
            m = rand_payload();
            case (n % 3)
                0: m.gototrap = 1'b1;
                1: begin
                    m.returnfromtrap = (n < 3) ? RET_MRET : RET_SRET;
                    m.instret        = 1'b1;
                end
                default: m.instret = 1'b1;
            endcase
            issue_slot(m, (n % 2) ? 3 : 0);       // every other slot stalled
            exp_traps   += m.gototrap;
            exp_rets    += (m.returnfromtrap != RET_NONE);
            exp_instret += m.instret;
        end
        settle();
    endtask

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        exp_instret    = '0;
        exp_traps      = '0;
        exp_rets       = '0;
        test_name      = "init";
        for (int i = 0; i < `RISCV_REG_COUNT; i++) begin
            shadow_regs[i] = '0;
        end
        rst     = 1'b1;
        rs1addr = '0;
        rs2addr = '0;
        drive_idle();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_reset_passthrough();
        test_load_align();
        test_result_select();
        test_flush();
        test_stall();
        test_trap_counters();

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/riscv_isa_pkg.sv
src/riscv_pipe_pkg.sv
src/riscv_load_align.sv
src/riscv_ppreg_mw.sv
src/riscv_wb_mux.sv
src/riscv_regfile.sv
src/riscv_retire_counter.sv
src/riscv_mw_top.sv
sim/tb_riscv_mw_top.sv
